// ==== lcd_text_defines.svh ====
`ifndef LCD_TEXT_DEFINES_SVH
`define LCD_TEXT_DEFINES_SVH

// Display power-up and bus write timing in clocks
`define LCD_POWERUP_CYCLES    70
`define LCD_EN_SETUP_CYCLES   1
`define LCD_EN_HIGH_CYCLES    2
`define LCD_EN_HOLD_CYCLES    1

// Setup commands
`define LCD_CMD_FUNCTION_SET  8'h38  // 8-bit bus, 2 lines, 5x8 font
`define LCD_CMD_DISPLAY_ON    8'h0F  // Display, cursor and blink on
`define LCD_CMD_ENTRY_MODE    8'h06  // Increment, no shift

// DDRAM set-address commands
`define LCD_ADDR_LINE1        8'h80
`define LCD_ADDR_LINE2        8'hC0

// Line geometry
`define LCD_LINE_CHARS        16
`define LCD_CHAR_BLANK        8'h20

`endif

// ==== lcd_text_pkg.sv ====
`default_nettype none

package lcd_text_pkg;

  typedef logic [7:0] lcd_byte_t;

  // 0 is the address slot, 1 to 16 are characters
  typedef logic [4:0] lcd_col_t;

  typedef logic [3:0] game_code_t;

  typedef enum logic [2:0] {
    STEP_FUNCTION_SET,
    STEP_DISPLAY_ON,
    STEP_ENTRY_MODE,
    STEP_LINE1,
    STEP_LINE2
  } step_kind_e;

  typedef enum logic [2:0] {
    MSG_BLANK,
    MSG_UP,
    MSG_DOWN,
    MSG_GAME_OVER,
    MSG_SUCCESS
  } msg_sel_e;

endpackage

`default_nettype wire

// ==== lcd_text_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Step stream from sequencer to mapper
interface lcd_step_if;
  logic                     valid;
  logic                     ready;
  lcd_text_pkg::step_kind_e kind;
  lcd_text_pkg::lcd_col_t   col;

  modport source (
    output valid,
    output kind,
    output col,
    input  ready
  );

  modport sink (
    input  valid,
    input  kind,
    input  col,
    output ready
  );
endinterface

// Byte stream from mapper to bus writer
interface lcd_byte_if;
  logic                    valid;
  logic                    ready;
  logic                    rs;
  lcd_text_pkg::lcd_byte_t data;

  modport source (output valid, output rs, output data, input ready);
  modport sink (input valid, input rs, input data, output ready);
endinterface

`default_nettype wire

// ==== lcd_step_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_text_defines.svh"

module lcd_step_sequencer (
  input  wire logic   clk,
  input  wire logic   reset,
  lcd_step_if.source  step
);

  localparam int unsigned PWR_W = $clog2(`LCD_POWERUP_CYCLES);

  logic [PWR_W-1:0]         pwr_cnt;
  logic                     running;  // Power-up wait is over
  lcd_text_pkg::step_kind_e kind;
  lcd_text_pkg::lcd_col_t   col;
  logic                     xfer;

  assign xfer = running && step.ready;

  assign step.valid = running;
  assign step.kind  = kind;
  assign step.col   = col;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      pwr_cnt <= '0;
      running <= 1'b0;
    end else if (!running) begin
      if (pwr_cnt == PWR_W'(`LCD_POWERUP_CYCLES - 1)) begin
        running <= 1'b1;
      end else begin
        pwr_cnt <= pwr_cnt + PWR_W'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      kind <= lcd_text_pkg::STEP_FUNCTION_SET;
      col  <= '0;
    end else if (xfer) begin
      case (kind)
        lcd_text_pkg::STEP_FUNCTION_SET: kind <= lcd_text_pkg::STEP_DISPLAY_ON;
        lcd_text_pkg::STEP_DISPLAY_ON:   kind <= lcd_text_pkg::STEP_ENTRY_MODE;
        lcd_text_pkg::STEP_ENTRY_MODE: begin
          kind <= lcd_text_pkg::STEP_LINE1;
          col  <= '0;
        end
        lcd_text_pkg::STEP_LINE1, lcd_text_pkg::STEP_LINE2: begin
          if (col == lcd_text_pkg::lcd_col_t'(`LCD_LINE_CHARS)) begin
            col <= '0;
            // Alternate lines forever
            if (kind == lcd_text_pkg::STEP_LINE1) begin
              kind <= lcd_text_pkg::STEP_LINE2;
            end else begin
              kind <= lcd_text_pkg::STEP_LINE1;
            end
          end else begin
            col <= col + lcd_text_pkg::lcd_col_t'(1);
          end
        end
        default: begin
          kind <= lcd_text_pkg::STEP_FUNCTION_SET;
          col  <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== lcd_char_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_text_defines.svh"

module lcd_char_mapper (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire lcd_text_pkg::game_code_t wrong,
  input  wire lcd_text_pkg::game_code_t correct,
  input  wire lcd_text_pkg::game_code_t up_down,
  lcd_step_if.sink                      step,
  lcd_byte_if.source                    bytes
);

  localparam int unsigned LINE_W = 8 * `LCD_LINE_CHARS;

  localparam logic [LINE_W-1:0] LINE1_TEXT  = {"UP & DOWN Game", {2{`LCD_CHAR_BLANK}}};
  localparam logic [LINE_W-1:0] UP_TEXT     = {"UP", {14{`LCD_CHAR_BLANK}}};
  localparam logic [LINE_W-1:0] DOWN_TEXT   = {"DOWN", {12{`LCD_CHAR_BLANK}}};
  localparam logic [LINE_W-1:0] OVER_TEXT   = {"Game over", {7{`LCD_CHAR_BLANK}}};
  localparam logic [LINE_W-1:0] SUCCES_TEXT = {"Success!", {8{`LCD_CHAR_BLANK}}};
  localparam logic [LINE_W-1:0] BLANK_TEXT  = {`LCD_LINE_CHARS{`LCD_CHAR_BLANK}};

  logic                      out_valid;
  logic                      out_rs;
  lcd_text_pkg::lcd_byte_t   out_data;
  lcd_text_pkg::msg_sel_e    msg;
  lcd_text_pkg::msg_sel_e    msg_next;
  logic                      map_rs;
  lcd_text_pkg::lcd_byte_t   map_data;
  logic                      step_xfer;

  // Column 1 is the leftmost character, held in the top byte
  function automatic lcd_text_pkg::lcd_byte_t text_char(input logic [LINE_W-1:0] text,
                                                        input lcd_text_pkg::lcd_col_t col);
    int unsigned idx;
    idx = `LCD_LINE_CHARS - col;
    return text[8*idx +: 8];
  endfunction

  function automatic logic [LINE_W-1:0] msg_text(input lcd_text_pkg::msg_sel_e sel);
    case (sel)
      lcd_text_pkg::MSG_UP:        return UP_TEXT;
      lcd_text_pkg::MSG_DOWN:      return DOWN_TEXT;
      lcd_text_pkg::MSG_GAME_OVER: return OVER_TEXT;
      lcd_text_pkg::MSG_SUCCESS:   return SUCCES_TEXT;
      default:                     return BLANK_TEXT;
    endcase
  endfunction

  always_comb begin
    if (wrong == '0 && correct == '0) msg_next = lcd_text_pkg::MSG_BLANK;
    else if (up_down == 4'd1)         msg_next = lcd_text_pkg::MSG_UP;
    else if (up_down == 4'd2)         msg_next = lcd_text_pkg::MSG_DOWN;
    else if (up_down == 4'd5)         msg_next = lcd_text_pkg::MSG_GAME_OVER;
    else if (correct != '0)           msg_next = lcd_text_pkg::MSG_SUCCESS;
    else                              msg_next = msg;  // Keep previous
  end

  always_comb begin
    map_rs   = 1'b0;
    map_data = `LCD_CHAR_BLANK;
    case (step.kind)
      lcd_text_pkg::STEP_FUNCTION_SET: map_data = `LCD_CMD_FUNCTION_SET;
      lcd_text_pkg::STEP_DISPLAY_ON:   map_data = `LCD_CMD_DISPLAY_ON;
      lcd_text_pkg::STEP_ENTRY_MODE:   map_data = `LCD_CMD_ENTRY_MODE;
      lcd_text_pkg::STEP_LINE1: begin
        if (step.col == '0) begin
          map_data = `LCD_ADDR_LINE1;
        end else begin
          map_rs   = 1'b1;
          map_data = text_char(LINE1_TEXT, step.col);
        end
      end
      lcd_text_pkg::STEP_LINE2: begin
        if (step.col == '0) begin
          map_data = `LCD_ADDR_LINE2;
        end else begin
          map_rs   = 1'b1;
          map_data = text_char(msg_text(msg), step.col);  // Latched at column 0
        end
      end
      default: ;
    endcase
  end

  assign step_xfer  = step.valid && step.ready;
  assign step.ready = !out_valid || bytes.ready;

  assign bytes.valid = out_valid;
  assign bytes.rs    = out_rs;
  assign bytes.data  = out_data;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      out_valid <= 1'b0;
      msg       <= lcd_text_pkg::MSG_BLANK;
    end else begin
      if (step_xfer) begin
        out_valid <= 1'b1;
      end else if (bytes.ready) begin
        out_valid <= 1'b0;
      end
      if (step_xfer && step.kind == lcd_text_pkg::STEP_LINE2 && step.col == '0) begin
        msg <= msg_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step_xfer) begin
      out_rs   <= map_rs;
      out_data <= map_data;
    end
  end

endmodule

`default_nettype wire

// ==== lcd_bus_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_text_defines.svh"

module lcd_bus_writer (
  input  wire logic               clk,
  input  wire logic               reset,
  lcd_byte_if.sink                bytes,
  output logic                    lcd_en,
  output logic                    lcd_rs,
  output logic                    lcd_rw,
  output lcd_text_pkg::lcd_byte_t lcd_data
);

  localparam int unsigned EN_RISE = `LCD_EN_SETUP_CYCLES;
  localparam int unsigned EN_FALL = `LCD_EN_SETUP_CYCLES + `LCD_EN_HIGH_CYCLES;
  localparam int unsigned TOTAL   = EN_FALL + `LCD_EN_HOLD_CYCLES;
  localparam int unsigned CNT_W   = $clog2(TOTAL);

  logic [CNT_W-1:0] phase;  // 0 is idle and the last hold cycle
  logic             xfer;

  assign bytes.ready = (phase == '0);
  assign xfer        = bytes.valid && bytes.ready;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      phase    <= '0;
      lcd_en   <= 1'b0;
      lcd_rs   <= 1'b1;
      lcd_rw   <= 1'b1;
      lcd_data <= '0;
    end else begin
      if (xfer) begin
        phase    <= CNT_W'(1);
        lcd_rs   <= bytes.rs;
        lcd_data <= bytes.data;
        lcd_rw   <= 1'b0;  // Write only from here on
      end else if (phase != '0) begin
        if (phase == CNT_W'(TOTAL - 1)) begin
          phase <= '0;
        end else begin
          phase <= phase + CNT_W'(1);
        end
      end

      if (phase == CNT_W'(EN_RISE)) begin
        lcd_en <= 1'b1;
      end else if (phase == CNT_W'(EN_FALL)) begin
        lcd_en <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== lcd_text_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_text_top (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire lcd_text_pkg::game_code_t wrong,
  input  wire lcd_text_pkg::game_code_t correct,
  input  wire lcd_text_pkg::game_code_t up_down,
  output logic                          lcd_en,
  output logic                          lcd_rs,
  output logic                          lcd_rw,
  output lcd_text_pkg::lcd_byte_t       lcd_data
);

  lcd_step_if u_step_if ();
  lcd_byte_if u_byte_if ();

  // Power-up wait and step ordering
  lcd_step_sequencer u_sequencer (
    .clk   (clk),
    .reset (reset),
    .step  (u_step_if.source)
  );

  lcd_char_mapper u_mapper (
    .clk     (clk),
    .reset   (reset),
    .wrong   (wrong),
    .correct (correct),
    .up_down (up_down),
    .step    (u_step_if.sink),
    .bytes   (u_byte_if.source)
  );

  // Pin timing and back-pressure source
  lcd_bus_writer u_writer (
    .clk      (clk),
    .reset    (reset),
    .bytes    (u_byte_if.sink),
    .lcd_en   (lcd_en),
    .lcd_rs   (lcd_rs),
    .lcd_rw   (lcd_rw),
    .lcd_data (lcd_data)
  );

endmodule

`default_nettype wire

// ==== tb_lcd_text.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_text_defines.svh"

module tb_lcd_text;

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_PASSES      = 12;
  localparam int BYTES_PER_PASS  = 2 * (`LCD_LINE_CHARS + 1);
  localparam int TOTAL_BYTES     = 3 + NUM_PASSES * BYTES_PER_PASS;
  localparam int WATCHDOG_CYCLES = `LCD_POWERUP_CYCLES + 3 + NUM_PASSES * BYTES_PER_PASS * 8;
  localparam int MSG_KEEP        = 5;  // No rule matched

  logic                       clk;
  logic                       reset;
  lcd_text_pkg::game_code_t   wrong;
  lcd_text_pkg::game_code_t   correct;
  lcd_text_pkg::game_code_t   up_down;
  logic                       lcd_en;
  logic                       lcd_rs;
  logic                       lcd_rw;
  lcd_text_pkg::lcd_byte_t    lcd_data;

  logic                       en_prev = 1'b0;
  logic                       cap_rs;
  lcd_text_pkg::lcd_byte_t    cap_data;
  int                         high_cycles = 0;
  int                         clocks_since_release = 0;
  int                         byte_count = 0;
  int                         line1_count = 0;
  int                         msg_model = 0;  // Blank after reset

  lcd_text_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .wrong    (wrong),
    .correct  (correct),
    .up_down  (up_down),
    .lcd_en   (lcd_en),
    .lcd_rs   (lcd_rs),
    .lcd_rw   (lcd_rw),
    .lcd_data (lcd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  function automatic string pad_line(input string s);
    string r;
    r = s;
    while (r.len() < `LCD_LINE_CHARS) r = {r, " "};
    return r;
  endfunction

  function automatic string message_text(input int msg);
    case (msg)
      1:       return pad_line("UP");
      2:       return pad_line("DOWN");
      3:       return pad_line("Game over");
      4:       return pad_line("Success!");
      default: return pad_line("");
    endcase
  endfunction

  // Priority rule for the line-2 selection
  function automatic int select_message(input int w, input int c, input int u);
    if (w == 0 && c == 0) return 0;
    if (u == 1) return 1;
    if (u == 2) return 2;
    if (u == 5) return 3;
    if (c != 0) return 4;
    return MSG_KEEP;
  endfunction

  // Returns {rs, byte} for byte number idx of the run
  function automatic logic [8:0] expected_byte(input int idx, input int msg);
    int    pos;
    int    col;
    string text;
    if (idx == 0) return {1'b0, 8'h38};
    if (idx == 1) return {1'b0, 8'h0F};
    if (idx == 2) return {1'b0, 8'h06};
    pos = (idx - 3) % BYTES_PER_PASS;
    col = pos % (`LCD_LINE_CHARS + 1);
    if (col == 0) return {1'b0, (pos == 0) ? 8'h80 : 8'hC0};
    if (pos <= `LCD_LINE_CHARS) text = pad_line("UP & DOWN Game");
    else text = message_text(msg);
    return {1'b1, text[col-1]};
  endfunction

  task automatic drive_inputs(input int w, input int c, input int u);
    wrong   <= lcd_text_pkg::game_code_t'(w);
    correct <= lcd_text_pkg::game_code_t'(c);
    up_down <= lcd_text_pkg::game_code_t'(u);
  endtask

  // Bus monitor and comparison on values sampled before each clock edge
  always @(posedge clk) begin
    if (reset) begin
      clocks_since_release++;
      if (lcd_en && !en_prev) begin
        if (clocks_since_release <= `LCD_POWERUP_CYCLES) begin
          $display("Enable pulse came %0d clocks after reset release, before power-up ended",
                   clocks_since_release);
          abort_run();
        end
        check_equal(lcd_rw, 1'b0, "lcd_rw at enable rise");
        cap_rs      = lcd_rs;
        cap_data    = lcd_data;
        high_cycles = 1;
        if (byte_count >= 3 && (byte_count - 3) % BYTES_PER_PASS == `LCD_LINE_CHARS + 1) begin
          if (select_message(wrong, correct, up_down) != MSG_KEEP) begin
            msg_model = select_message(wrong, correct, up_down);
          end
        end
        if (byte_count >= 3 && (byte_count - 3) % BYTES_PER_PASS == 0) line1_count++;
        check_equal({lcd_rs, lcd_data}, expected_byte(byte_count, msg_model),
                    $sformatf("byte %0d {rs,data}", byte_count));
        byte_count++;
      end else if (lcd_en) begin
        high_cycles++;
        check_equal({lcd_rs, lcd_data}, {cap_rs, cap_data}, "bus change while enable high");
      end else if (en_prev) begin
        check_equal(high_cycles, `LCD_EN_HIGH_CYCLES, "enable high length");
        check_equal({lcd_rs, lcd_data}, {cap_rs, cap_data}, "bus change in hold cycle");
      end
    end
    en_prev = lcd_en;
  end

  // New game inputs just after each line-1 address byte
  initial begin : stimulus
    int p;
    void'($urandom(85));
    for (p = 1; p < NUM_PASSES; p++) begin
      wait (line1_count > p);
      @(posedge clk);
      case (p)
        1:       drive_inputs(1, 0, 1);  // UP
        2:       drive_inputs(1, 0, 2);  // DOWN
        3:       drive_inputs(1, 0, 5);
        4:       drive_inputs(0, 1, 0);  // Success
        5:       drive_inputs(2, 0, 7);  // Keep previous
        6:       drive_inputs(0, 0, 1);  // Blank wins over UP
        default: drive_inputs($urandom % 4, $urandom % 2, $urandom % 8);
      endcase
    end
  end

  initial begin
    reset   = 1'b0;
    wrong   = '0;
    correct = '0;
    up_down = '0;
    repeat (3) @(posedge clk);
    check_equal(lcd_en, 1'b0, "lcd_en during reset");
    check_equal(lcd_rw, 1'b1, "lcd_rw during reset");
    check_equal(lcd_rs, 1'b1, "lcd_rs during reset");
    check_equal(lcd_data, 8'h00, "lcd_data during reset");
    reset <= 1'b1;
    wait (byte_count >= TOTAL_BYTES);
    repeat (4) @(posedge clk);  // Let the last hold check run
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: only %0d of %0d LCD bytes were written", byte_count, TOTAL_BYTES);
    abort_run();
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
lcd_text_pkg.sv
lcd_text_ifs.sv
lcd_step_sequencer.sv
lcd_char_mapper.sv
lcd_bus_writer.sv
lcd_text_top.sv
tb_lcd_text.sv

// ==== Bender.yml ====
package:
  name: lcd_text

export_include_dirs:
  - .

sources:
  - files:
      - lcd_text_pkg.sv
      - lcd_text_ifs.sv
      - lcd_step_sequencer.sv
      - lcd_char_mapper.sv
      - lcd_bus_writer.sv
      - lcd_text_top.sv
  - target: simulation
    files:
      - tb_lcd_text.sv
